// ==== src/dcp_defs.svh ====
`ifndef DCP_DEFS_SVH
`define DCP_DEFS_SVH

// words printed per D command
`define DCP_DUMP_WORDS 8

// register file entries printed by R
`define DCP_REG_COUNT 32

// hex digits per word for print and parse
`define DCP_HEX_DIGITS 8

`endif

// ==== src/dcp_types_pkg.sv ====
package dcp_types_pkg;

    // one character on the serial link
    typedef logic [7:0] byte_t;

    // cpu word for addresses, data and arguments
    typedef logic [31:0] word_t;

    // register file index
    typedef logic [4:0] reg_idx_t;

endpackage

// ==== src/dcp_cmd_pkg.sv ====
package dcp_cmd_pkg;

    // command letters as ascii codes
    typedef enum logic [7:0] {
        CMD_D = 8'h44,
        CMD_R = 8'h52
    } cmd_code_t;

    // mode of a scan or print request
    typedef enum logic {
        XFER_CHAR = 1'b0,
        XFER_WORD = 1'b1
    } xfer_kind_t;

    // dispatcher states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_RUN,
        ST_DISCARD
    } dcp_state_t;

endpackage

// ==== src/dcp_scan.sv ====
`timescale 1ns/10ps

module dcp_scan (
    input  logic                    clk,
    input  logic                    rstn,
    input  dcp_types_pkg::byte_t    d_rx,
    input  logic                    vld_rx,
    output logic                    rdy_rx,
    input  logic                    scan_req,
    input  dcp_cmd_pkg::xfer_kind_t scan_kind,
    output logic                    scan_ack,
    output logic                    scan_flag,
    output logic                    line_end,
    output dcp_types_pkg::word_t    scan_data
);

    typedef enum logic [2:0] {
        SC_IDLE,
        SC_SKIP,
        SC_WORD,
        SC_FLUSH,
        SC_DONE
    } scan_state_t;

    scan_state_t             state;
    dcp_cmd_pkg::xfer_kind_t kind_q;
    logic                    fire;
    logic                    is_space;
    logic                    is_eol;
    logic                    is_hex;
    logic [3:0]              nib;

    // only take bytes while a request is open
    assign rdy_rx   = scan_req && (state inside {SC_SKIP, SC_WORD, SC_FLUSH});
    assign fire     = vld_rx && rdy_rx;
    assign scan_ack = (state == SC_DONE);
    assign is_space = (d_rx == 8'h20);
    assign is_eol   = (d_rx == 8'h0D) || (d_rx == 8'h0A);

    // hex digit decode for either case
    always_comb
    begin
        is_hex = 1'b1;
        nib    = d_rx[3:0];
        if ((d_rx >= 8'h41 && d_rx <= 8'h46) || (d_rx >= 8'h61 && d_rx <= 8'h66))
            nib = d_rx[3:0] + 4'd9;
        else if (d_rx < 8'h30 || d_rx > 8'h39)
            is_hex = 1'b0;
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state  <= SC_IDLE;
            kind_q <= dcp_cmd_pkg::XFER_CHAR;
        end
        else
        begin
            case (state)
                SC_IDLE:
                    if (scan_req)
                    begin
                        state  <= SC_SKIP;
                        kind_q <= scan_kind;
                    end
                SC_SKIP:
                    if (fire && !is_space)
                    begin
                        if (kind_q == dcp_cmd_pkg::XFER_CHAR || is_eol)
                            state <= SC_DONE;
                        else if (is_hex)
                            state <= SC_WORD;
                        else
                            state <= SC_FLUSH;
                    end
                SC_WORD:
                    if (fire)
                    begin
                        if (is_space || is_eol)
                            state <= SC_DONE;
                        else if (!is_hex)
                            state <= SC_FLUSH;
                    end
                // junk inside a word drops the rest of the line
                SC_FLUSH:
                    if (fire && is_eol)
                        state <= SC_DONE;
                default:
                    state <= SC_IDLE;
            endcase
        end
    end

    // result registers cleared between requests
    always_ff @(posedge clk)
    begin
        if (state == SC_IDLE)
        begin
            scan_data <= '0;
            scan_flag <= 1'b0;
            line_end  <= 1'b0;
        end
        else if (fire)
        begin
            if (is_eol)
                line_end <= 1'b1;
            if (state == SC_SKIP && !is_space)
            begin
                if (kind_q == dcp_cmd_pkg::XFER_CHAR)
                begin
                    scan_data <= {24'b0, d_rx};
                    scan_flag <= is_eol;
                end
                else if (is_hex)
                    scan_data <= {28'b0, nib};
                else
                    scan_flag <= 1'b1;
            end
            else if (state == SC_WORD)
            begin
                // older digits fall off the top
                if (is_hex)
                    scan_data <= {scan_data[27:0], nib};
                else if (!is_space && !is_eol)
                    scan_flag <= 1'b1;
            end
        end
    end

endmodule

// ==== src/dcp_print.sv ====
`timescale 1ns/10ps

`include "dcp_defs.svh"

module dcp_print (
    input  logic                    clk,
    input  logic                    rstn,
    output dcp_types_pkg::byte_t    d_tx,
    output logic                    vld_tx,
    input  logic                    rdy_tx,
    input  logic                    print_req,
    input  dcp_cmd_pkg::xfer_kind_t print_kind,
    input  dcp_types_pkg::word_t    print_data,
    output logic                    print_ack
);

    localparam int CNT_W = $clog2(`DCP_HEX_DIGITS);

    typedef enum logic [1:0] {
        PR_IDLE,
        PR_SEND,
        PR_ACK
    } print_state_t;

    print_state_t            state;
    dcp_cmd_pkg::xfer_kind_t kind_q;
    dcp_types_pkg::word_t    data_q;
    logic [CNT_W-1:0]        cnt;
    logic                    fire;
    logic                    last;
    logic [3:0]              nib;

    assign vld_tx    = (state == PR_SEND);
    assign fire      = vld_tx && rdy_tx;
    assign print_ack = (state == PR_ACK);
    assign last      = (kind_q == dcp_cmd_pkg::XFER_CHAR) ||
                       (cnt == CNT_W'(`DCP_HEX_DIGITS - 1));
    assign nib       = data_q[31:28];

    // upper-case ascii hex from the top nibble
    always_comb
    begin
        if (kind_q == dcp_cmd_pkg::XFER_CHAR)
            d_tx = data_q[7:0];
        else if (nib < 4'd10)
            d_tx = 8'h30 + {4'b0, nib};
        else
            d_tx = 8'h37 + {4'b0, nib};
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= PR_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                PR_IDLE:
                    if (print_req)
                    begin
                        state <= PR_SEND;
                        cnt   <= '0;
                    end
                PR_SEND:
                    if (fire)
                    begin
                        if (last)
                            state <= PR_ACK;
                        else
                            cnt <= cnt + 1'b1;
                    end
                default:
                    state <= PR_IDLE;
            endcase
        end
    end

    // shift only on an accepted byte so d_tx holds under back-pressure
    always_ff @(posedge clk)
    begin
        if (state == PR_IDLE && print_req)
        begin
            kind_q <= print_kind;
            data_q <= print_data;
        end
        else if (fire)
            data_q <= {data_q[27:0], 4'h0};
    end

endmodule

// ==== src/dcp_cmd_dump.sv ====
`timescale 1ns/10ps

`include "dcp_defs.svh"

module dcp_cmd_dump (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start,
    output logic                    done,
    output logic                    scan_req,
    output dcp_cmd_pkg::xfer_kind_t scan_kind,
    input  logic                    scan_ack,
    input  logic                    scan_flag,
    input  logic                    line_end,
    input  dcp_types_pkg::word_t    scan_data,
    output logic                    print_req,
    output dcp_cmd_pkg::xfer_kind_t print_kind,
    output dcp_types_pkg::word_t    print_data,
    input  logic                    print_ack,
    output dcp_types_pkg::word_t    mem_addr,
    input  dcp_types_pkg::word_t    dout_dm
);

    localparam int CNT_W = $clog2(`DCP_DUMP_WORDS + 1);

    typedef enum logic [3:0] {
        DM_IDLE,
        DM_ARG,
        DM_EOL,
        DM_ADDR,
        DM_COLON,
        DM_SPACE,
        DM_DATA,
        DM_LF,
        DM_DONE
    } dump_state_t;

    dump_state_t          state;
    dcp_types_pkg::word_t addr_q;
    logic [CNT_W-1:0]     cnt;

    assign done       = (state == DM_DONE);
    assign scan_req   = (state inside {DM_ARG, DM_EOL});
    assign scan_kind  = (state == DM_ARG) ? dcp_cmd_pkg::XFER_WORD : dcp_cmd_pkg::XFER_CHAR;
    assign print_req  = (state inside {DM_ADDR, DM_COLON, DM_SPACE, DM_DATA, DM_LF});
    assign print_kind = (state inside {DM_ADDR, DM_DATA}) ?
                        dcp_cmd_pkg::XFER_WORD : dcp_cmd_pkg::XFER_CHAR;
    assign mem_addr   = addr_q;

    // one line is "addr: data\n"
    always_comb
    begin
        case (state)
            DM_ADDR:  print_data = addr_q;
            DM_COLON: print_data = 32'h3A;
            DM_SPACE: print_data = 32'h20;
            DM_DATA:  print_data = dout_dm;
            default:  print_data = 32'h0A;
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= DM_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                DM_IDLE:
                    if (start)
                    begin
                        state <= DM_ARG;
                        cnt   <= '0;
                    end
                // bad argument ends the command silently
                DM_ARG:
                    if (scan_ack)
                    begin
                        if (scan_flag)
                            state <= DM_DONE;
                        else if (line_end)
                            state <= DM_ADDR;
                        else
                            state <= DM_EOL;
                    end
                DM_EOL:
                    if (scan_ack && line_end)
                        state <= DM_ADDR;
                DM_ADDR:
                    if (print_ack)
                        state <= DM_COLON;
                DM_COLON:
                    if (print_ack)
                        state <= DM_SPACE;
                DM_SPACE:
                    if (print_ack)
                        state <= DM_DATA;
                DM_DATA:
                    if (print_ack)
                        state <= DM_LF;
                DM_LF:
                    if (print_ack)
                    begin
                        if (cnt == CNT_W'(`DCP_DUMP_WORDS - 1))
                            state <= DM_DONE;
                        else
                        begin
                            cnt   <= cnt + 1'b1;
                            state <= DM_ADDR;
                        end
                    end
                default:
                    state <= DM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == DM_ARG && scan_ack)
            addr_q <= scan_data;
        else if (state == DM_LF && print_ack)
            addr_q <= addr_q + 32'd4;
    end

endmodule

// ==== src/dcp_cmd_regs.sv ====
`timescale 1ns/10ps

`include "dcp_defs.svh"

module dcp_cmd_regs (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start,
    output logic                    done,
    output logic                    print_req,
    output dcp_cmd_pkg::xfer_kind_t print_kind,
    output dcp_types_pkg::word_t    print_data,
    input  logic                    print_ack,
    output dcp_types_pkg::reg_idx_t reg_idx,
    input  dcp_types_pkg::word_t    dout_rf
);

    typedef enum logic [1:0] {
        RG_IDLE,
        RG_VAL,
        RG_LF,
        RG_DONE
    } regs_state_t;

    regs_state_t             state;
    dcp_types_pkg::reg_idx_t idx;

    assign done       = (state == RG_DONE);
    assign print_req  = (state inside {RG_VAL, RG_LF});
    assign print_kind = (state == RG_VAL) ? dcp_cmd_pkg::XFER_WORD : dcp_cmd_pkg::XFER_CHAR;
    // register value, then a line feed
    assign print_data = (state == RG_VAL) ? dout_rf : 32'h0A;
    assign reg_idx    = idx;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= RG_IDLE;
            idx   <= '0;
        end
        else
        begin
            case (state)
                RG_IDLE:
                    if (start)
                    begin
                        idx   <= '0;
                        state <= RG_VAL;
                    end
                RG_VAL:
                    if (print_ack)
                        state <= RG_LF;
                RG_LF:
                    if (print_ack)
                    begin
                        if (idx == dcp_types_pkg::reg_idx_t'(`DCP_REG_COUNT - 1))
                            state <= RG_DONE;
                        else
                        begin
                            idx   <= idx + 1'b1;
                            state <= RG_VAL;
                        end
                    end
                default:
                    state <= RG_IDLE;
            endcase
        end
    end

endmodule

// ==== src/dcp.sv ====
`timescale 1ns/10ps

module dcp (
    input  logic                 clk,
    input  logic                 rstn,
    input  dcp_types_pkg::byte_t d_rx,
    input  logic                 vld_rx,
    output logic                 rdy_rx,
    output dcp_types_pkg::byte_t d_tx,
    output logic                 vld_tx,
    input  logic                 rdy_tx,
    output dcp_types_pkg::word_t addr,
    input  dcp_types_pkg::word_t dout_rf,
    input  dcp_types_pkg::word_t dout_dm
);

    // owner of the shared scan and print blocks
    typedef enum logic [1:0] {
        SEL_DISP,
        SEL_DUMP,
        SEL_REGS
    } sel_t;

    dcp_cmd_pkg::dcp_state_t state;
    sel_t                    sel_q;
    logic                    pend_regs;
    logic                    start_dump;
    logic                    start_regs;

    logic                    scan_req;
    dcp_cmd_pkg::xfer_kind_t scan_kind;
    logic                    scan_ack;
    logic                    scan_flag;
    logic                    line_end;
    dcp_types_pkg::word_t    scan_data;
    logic                    print_req;
    dcp_cmd_pkg::xfer_kind_t print_kind;
    dcp_types_pkg::word_t    print_data;
    logic                    print_ack;

    logic                    dump_done;
    logic                    dump_scan_req;
    dcp_cmd_pkg::xfer_kind_t dump_scan_kind;
    logic                    dump_print_req;
    dcp_cmd_pkg::xfer_kind_t dump_print_kind;
    dcp_types_pkg::word_t    dump_print_data;
    dcp_types_pkg::word_t    dump_addr;

    logic                    regs_done;
    logic                    regs_print_req;
    dcp_cmd_pkg::xfer_kind_t regs_print_kind;
    dcp_types_pkg::word_t    regs_print_data;
    dcp_types_pkg::reg_idx_t regs_idx;

    dcp_scan scan_i (
        .clk       (clk),
        .rstn      (rstn),
        .d_rx      (d_rx),
        .vld_rx    (vld_rx),
        .rdy_rx    (rdy_rx),
        .scan_req  (scan_req),
        .scan_kind (scan_kind),
        .scan_ack  (scan_ack),
        .scan_flag (scan_flag),
        .line_end  (line_end),
        .scan_data (scan_data)
    );

    dcp_print print_i (
        .clk        (clk),
        .rstn       (rstn),
        .d_tx       (d_tx),
        .vld_tx     (vld_tx),
        .rdy_tx     (rdy_tx),
        .print_req  (print_req),
        .print_kind (print_kind),
        .print_data (print_data),
        .print_ack  (print_ack)
    );

    dcp_cmd_dump dump_i (
        .clk        (clk),
        .rstn       (rstn),
        .start      (start_dump),
        .done       (dump_done),
        .scan_req   (dump_scan_req),
        .scan_kind  (dump_scan_kind),
        .scan_ack   (scan_ack),
        .scan_flag  (scan_flag),
        .line_end   (line_end),
        .scan_data  (scan_data),
        .print_req  (dump_print_req),
        .print_kind (dump_print_kind),
        .print_data (dump_print_data),
        .print_ack  (print_ack),
        .mem_addr   (dump_addr),
        .dout_dm    (dout_dm)
    );

    dcp_cmd_regs regs_i (
        .clk        (clk),
        .rstn       (rstn),
        .start      (start_regs),
        .done       (regs_done),
        .print_req  (regs_print_req),
        .print_kind (regs_print_kind),
        .print_data (regs_print_data),
        .print_ack  (print_ack),
        .reg_idx    (regs_idx),
        .dout_rf    (dout_rf)
    );

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state      <= dcp_cmd_pkg::ST_IDLE;
            sel_q      <= SEL_DISP;
            pend_regs  <= 1'b0;
            start_dump <= 1'b0;
            start_regs <= 1'b0;
        end
        else
        begin
            start_dump <= 1'b0;
            start_regs <= 1'b0;
            case (state)
                dcp_cmd_pkg::ST_IDLE:
                    state <= dcp_cmd_pkg::ST_FETCH;
                // empty line goes straight back to idle
                dcp_cmd_pkg::ST_FETCH:
                    if (scan_ack)
                    begin
                        if (scan_flag)
                            state <= dcp_cmd_pkg::ST_IDLE;
                        else
                        begin
                            case (scan_data[7:0])
                                dcp_cmd_pkg::CMD_D:
                                begin
                                    start_dump <= 1'b1;
                                    sel_q      <= SEL_DUMP;
                                    state      <= dcp_cmd_pkg::ST_RUN;
                                end
                                dcp_cmd_pkg::CMD_R:
                                begin
                                    pend_regs <= 1'b1;
                                    state     <= dcp_cmd_pkg::ST_DISCARD;
                                end
                                default:
                                begin
                                    pend_regs <= 1'b0;
                                    state     <= dcp_cmd_pkg::ST_DISCARD;
                                end
                            endcase
                        end
                    end
                // eat the line, then run R if it was pending
                dcp_cmd_pkg::ST_DISCARD:
                    if (scan_ack && line_end)
                    begin
                        if (pend_regs)
                        begin
                            start_regs <= 1'b1;
                            sel_q      <= SEL_REGS;
                            state      <= dcp_cmd_pkg::ST_RUN;
                        end
                        else
                            state <= dcp_cmd_pkg::ST_IDLE;
                    end
                default:
                    if (dump_done || regs_done)
                    begin
                        sel_q <= SEL_DISP;
                        state <= dcp_cmd_pkg::ST_IDLE;
                    end
            endcase
        end
    end

    // steer shared request lines to the active requester
    always_comb
    begin
        scan_req   = 1'b0;
        scan_kind  = dcp_cmd_pkg::XFER_CHAR;
        print_req  = 1'b0;
        print_kind = dcp_cmd_pkg::XFER_CHAR;
        print_data = '0;
        addr       = '0;
        case (sel_q)
            SEL_DUMP:
            begin
                scan_req   = dump_scan_req;
                scan_kind  = dump_scan_kind;
                print_req  = dump_print_req;
                print_kind = dump_print_kind;
                print_data = dump_print_data;
                addr       = dump_addr;
            end
            SEL_REGS:
            begin
                print_req  = regs_print_req;
                print_kind = regs_print_kind;
                print_data = regs_print_data;
                addr       = dcp_types_pkg::word_t'(regs_idx);
            end
            default:
                scan_req = (state inside {dcp_cmd_pkg::ST_FETCH, dcp_cmd_pkg::ST_DISCARD});
        endcase
    end

endmodule

// ==== verification/dcp_properties.sv ====
`timescale 1ns/10ps

module dcp_properties (
    input logic       clk,
    input logic       rstn,
    input logic [7:0] d_tx,
    input logic       vld_tx,
    input logic       rdy_tx,
    input logic       rdy_rx,
    input logic       scan_req,
    input logic       scan_ack,
    input logic       print_ack,
    input logic       start_dump,
    input logic       start_regs
);

    // count of failed assertions
    int violations = 0;

    // stalled byte holds until taken
    tx_stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        (vld_tx && !rdy_tx) |=> (vld_tx && $stable(d_tx)))
    else
    begin
        violations = violations + 1;
        $error("d_tx or vld_tx changed while the byte was stalled");
    end

    ack_pulses: assert property (@(posedge clk) disable iff (!rstn)
        (scan_ack || print_ack) |=> !((scan_ack && $past(scan_ack)) ||
                                      (print_ack && $past(print_ack))))
    else
    begin
        violations = violations + 1;
        $error("scan_ack or print_ack held longer than one cycle");
    end

    one_start: assert property (@(posedge clk) disable iff (!rstn)
        !(start_dump && start_regs))
    else
    begin
        violations = violations + 1;
        $error("both handler starts active together");
    end

    // no byte taken without an open scan request
    rx_idle: assert property (@(posedge clk) disable iff (!rstn)
        !scan_req |-> !rdy_rx)
    else
    begin
        violations = violations + 1;
        $error("rdy_rx high while no scan request is pending");
    end

endmodule

bind dcp dcp_properties props_i (
    .clk        (clk),
    .rstn       (rstn),
    .d_tx       (d_tx),
    .vld_tx     (vld_tx),
    .rdy_tx     (rdy_tx),
    .rdy_rx     (rdy_rx),
    .scan_req   (scan_req),
    .scan_ack   (scan_ack),
    .print_ack  (print_ack),
    .start_dump (start_dump),
    .start_regs (start_regs)
);

// ==== verification/dcp_tb.sv ====
`timescale 1ns/10ps

module dcp_tb;

    logic                 clk = 1'b0;
    logic                 rstn;
    dcp_types_pkg::byte_t d_rx;
    logic                 vld_rx;
    logic                 rdy_rx;
    dcp_types_pkg::byte_t d_tx;
    logic                 vld_tx;
    logic                 rdy_tx;
    dcp_types_pkg::word_t addr;
    dcp_types_pkg::word_t dout_rf;
    dcp_types_pkg::word_t dout_dm;

    // one entry per command line from the input file
    string                cmd_text[$];
    string                cmd_exp[$];
    int                   cmd_tx_gap[$];
    int                   cmd_rx_gap[$];

    logic [7:0]           exp_q[$];
    logic [7:0]           want;
    int                   tx_gap = 0;
    int                   rx_gap = 0;
    int                   rx_count = 0;
    int                   cycles = 0;
    int                   limit = 2000;

    always #4 clk = ~clk;

    dcp dut_i (
        .clk     (clk),
        .rstn    (rstn),
        .d_rx    (d_rx),
        .vld_rx  (vld_rx),
        .rdy_rx  (rdy_rx),
        .d_tx    (d_tx),
        .vld_tx  (vld_tx),
        .rdy_tx  (rdy_tx),
        .addr    (addr),
        .dout_rf (dout_rf),
        .dout_dm (dout_dm)
    );

    // cpu state models
    // upper address bits fold into the top half
    assign dout_dm = {addr[15:0] ^ addr[31:16], ~addr[15:0]};
    assign dout_rf = 32'h11111111 * {27'b0, addr[4:0]};

    task abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task compare_values(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
        if (actual !== expected)
        begin
            $display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task read_input();
        int    fd;
        int    tx_pct;
        int    rx_pct;
        int    last;
        string line;
        string kind;
        fd = $fopen("verification/dcp_input.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open verification/dcp_input.txt");
            abort_run();
        end
        tx_pct = 0;
        rx_pct = 0;
        while ($fgets(line, fd) != 0)
        begin
            while (line.len() > 0 && (line[line.len() - 1] == 8'h0A ||
                                      line[line.len() - 1] == 8'h0D))
                line = line.substr(0, line.len() - 2);
            if (line.len() == 0 || line[0] == 8'h23)
                continue;
            void'($sscanf(line, "%s", kind));
            last = cmd_text.size() - 1;
            if (kind == "gap")
                void'($sscanf(line, "gap %d %d", tx_pct, rx_pct));
            else if (kind == "cmd")
            begin
                cmd_text.push_back(line.substr(4, line.len() - 1));
                cmd_exp.push_back("");
                cmd_tx_gap.push_back(tx_pct);
                cmd_rx_gap.push_back(rx_pct);
            end
            else if (kind == "exp" && last >= 0)
                cmd_exp[last] = {cmd_exp[last], line.substr(4, line.len() - 1), "\n"};
            // output identical to the command before
            else if (kind == "same" && last >= 1)
                cmd_exp[last] = {cmd_exp[last], cmd_exp[last - 1]};
            else
            begin
                $display("bad record in input file: %s", line);
                abort_run();
            end
        end
        $fclose(fd);
    endtask

    task queue_expected(input string text);
        int k;
        for (k = 0; k < text.len(); k++)
            exp_q.push_back(text[k]);
    endtask

    task send_byte(input logic [7:0] value);
        while (int'($urandom_range(99)) < rx_gap)
        begin
            @(posedge clk);
            #1;
        end
        d_rx   = value;
        vld_rx = 1'b1;
        @(negedge clk);
        while (!rdy_rx)
            @(negedge clk);
        @(posedge clk);
        #1;
        vld_rx = 1'b0;
    endtask

    task send_line(input string text);
        int k;
        for (k = 0; k < text.len(); k++)
            send_byte(text[k]);
        send_byte(8'h0D);
    endtask

    // random stalls on the send side
    always @(posedge clk)
    begin
        #1;
        rdy_tx = (int'($urandom_range(99)) >= tx_gap);
    end

    // byte is taken at the next rising edge
    always @(negedge clk)
    begin
        if (rstn && vld_tx && rdy_tx)
        begin
            if (exp_q.size() == 0)
            begin
                $display("DUT sent byte 0x%0h when no more output was expected", d_tx);
                abort_run();
            end
            want = exp_q.pop_front();
            compare_values(32'(d_tx), 32'(want), $sformatf("output byte %0d", rx_count));
            rx_count = rx_count + 1;
        end
        if (dut_i.props_i.violations != 0)
        begin
            $display("a bound assertion on the DUT failed");
            abort_run();
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > limit)
        begin
            $display("timeout after %0d cycles with %0d output bytes still expected",
                     cycles, exp_q.size());
            abort_run();
        end
    end

    initial
    begin
        int i;
        int total;
        rstn   = 1'b0;
        d_rx   = 8'h00;
        vld_rx = 1'b0;
        rdy_tx = 1'b0;
        $timeformat(-9, 2, " ns", 0);
        void'($urandom(25589));
        read_input();
        total = 0;
        for (i = 0; i < cmd_exp.size(); i++)
            total = total + cmd_exp[i].len();
        limit = 400 * total + 2000;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (i = 0; i < cmd_text.size(); i++)
        begin
            tx_gap = cmd_tx_gap[i];
            rx_gap = cmd_rx_gap[i];
            queue_expected(cmd_exp[i]);
            send_line(cmd_text[i]);
        end
        // all output seen and the dispatcher waiting for a new line
        @(negedge clk);
        while (exp_q.size() != 0 || !rdy_rx)
            @(negedge clk);
        if (dut_i.props_i.violations == 0)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("bound assertions reported %0d violations", dut_i.props_i.violations);
            abort_run();
        end
    end

endmodule

// ==== verification/dcp_input.txt ====
# gap <rdy_tx gap percent> <vld_rx gap percent>, cmd <line sent with CR>
# exp <expected output line, LF implied>, same repeats the previous command's output
gap 0 0
cmd
cmd X 12
cmd D 1G0
cmd D
cmd D 1FC0
exp 00001FC0: 1FC0E03F
exp 00001FC4: 1FC4E03B
exp 00001FC8: 1FC8E037
exp 00001FCC: 1FCCE033
exp 00001FD0: 1FD0E02F
exp 00001FD4: 1FD4E02B
exp 00001FD8: 1FD8E027
exp 00001FDC: 1FDCE023
cmd    D   1fc0
same
cmd D 100
exp 00000100: 0100FEFF
exp 00000104: 0104FEFB
exp 00000108: 0108FEF7
exp 0000010C: 010CFEF3
exp 00000110: 0110FEEF
exp 00000114: 0114FEEB
exp 00000118: 0118FEE7
exp 0000011C: 011CFEE3
gap 40 30
cmd D 100
same
gap 0 0
cmd R
exp 00000000
exp 11111111
exp 22222222
exp 33333333
exp 44444444
exp 55555555
exp 66666666
exp 77777777
exp 88888888
exp 99999999
exp AAAAAAAA
exp BBBBBBBB
exp CCCCCCCC
exp DDDDDDDD
exp EEEEEEEE
exp FFFFFFFF
exp 11111110
exp 22222221
exp 33333332
exp 44444443
exp 55555554
exp 66666665
exp 77777776
exp 88888887
exp 99999998
exp AAAAAAA9
exp BBBBBBBA
exp CCCCCCCB
exp DDDDDDDC
exp EEEEEEED
exp FFFFFFFE
exp 1111110F
gap 40 30
cmd R
same

// ==== all.f ====
+incdir+src
src/dcp_types_pkg.sv
src/dcp_cmd_pkg.sv
src/dcp_scan.sv
src/dcp_print.sv
src/dcp_cmd_dump.sv
src/dcp_cmd_regs.sv
src/dcp.sv
verification/dcp_properties.sv
verification/dcp_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := dcp_tb
FILELIST  := all.f
VFLAGS    := --binary --timing --assert -Wno-fatal
SIM       := obj_dir/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)
PASS_TEXT := ALL TESTS PASSED

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
